//--- rtl/pipe_pkg.sv
package pipe_pkg;

  localparam int data_width     = 32;
  localparam int inst_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 16;

  // opcodes
  localparam logic [5:0] op_rtype = 6'd0;
  localparam logic [5:0] op_addi  = 6'd8;
  localparam logic [5:0] op_andi  = 6'd12;
  localparam logic [5:0] op_ori   = 6'd13;
  localparam logic [5:0] op_lw    = 6'd35;
  localparam logic [5:0] op_sw    = 6'd43;
  localparam logic [5:0] op_beq   = 6'd4;
  localparam logic [5:0] op_bne   = 6'd5;
  localparam logic [5:0] op_j     = 6'd2;

  // r-type function codes
  localparam logic [5:0] fn_add = 6'd32;
  localparam logic [5:0] fn_sub = 6'd34;
  localparam logic [5:0] fn_and = 6'd36;
  localparam logic [5:0] fn_or  = 6'd37;
  localparam logic [5:0] fn_slt = 6'd42;

  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_slt = 3'd4;

  // one instruction word, two layouts
  typedef union packed {
    struct packed {
      logic [5:0]                opcode;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [reg_addr_width-1:0] rd;
      logic [4:0]                shamt;
      logic [5:0]                funct;
    } r;
    struct packed {
      logic [5:0]                opcode;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [imm_width-1:0]      imm;
    } i;
  } instr_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int imem_addr_width = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic                       prog_valid,
  input  logic [imem_addr_width-1:0] prog_addr,
  input  pipe_pkg::instr_t           prog_data,
  input  logic                       stall,
  input  logic                       flush,
  input  logic                       hold,
  input  logic [imem_addr_width-1:0] redirect_pc,
  output logic                       prog_ready,
  output logic                       if_valid,
  output logic [imem_addr_width-1:0] if_pc,
  output pipe_pkg::instr_t           if_instr
);
  import pipe_pkg::*;

  logic [inst_width-1:0]      imem [2**imem_addr_width];
  logic [imem_addr_width-1:0] pc;

  assign prog_ready = !run;

  // program load only while parked
  always_ff @(posedge clk) begin
    if (prog_valid && prog_ready) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (!hold) begin
      if (flush) begin
        pc       <= redirect_pc;
        if_valid <= 1'b0;
      end else if (!stall) begin
        pc       <= pc + 1'b1;
        if_valid <= 1'b1;
      end
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (!hold && !stall) begin
      if_pc    <= pc;
      if_instr <= imem[pc];
    end
  end

  // a load lands only while fetch is parked at address 0
  a_load_parked: assert property (@(posedge clk) disable iff (!rst_n)
    prog_valid && prog_ready |=> pc == '0 && !if_valid);

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int imem_addr_width = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                run,
  input  logic                                if_valid,
  input  logic [imem_addr_width-1:0]          if_pc,
  input  pipe_pkg::instr_t                    if_instr,
  input  logic                                flush,
  input  logic                                hold,
  input  logic                                wb_write,
  input  logic [pipe_pkg::reg_addr_width-1:0] wb_reg,
  input  logic [pipe_pkg::data_width-1:0]     wb_data,
  output logic                                stall,
  output logic                                id_valid,
  output logic [imem_addr_width-1:0]          id_pc,
  output logic [2:0]                          id_alu_op,
  output logic                                id_alu_src,
  output logic                                id_mem_read,
  output logic                                id_mem_write,
  output logic                                id_reg_write,
  output logic                                id_branch_eq,
  output logic                                id_branch_ne,
  output logic                                id_jump,
  output logic [pipe_pkg::reg_addr_width-1:0] id_rs,
  output logic [pipe_pkg::reg_addr_width-1:0] id_rt,
  output logic [pipe_pkg::reg_addr_width-1:0] id_dst,
  output logic [pipe_pkg::data_width-1:0]     id_rs_data,
  output logic [pipe_pkg::data_width-1:0]     id_rt_data,
  output logic [pipe_pkg::imm_width-1:0]      id_imm
);
  import pipe_pkg::*;

  logic [data_width-1:0]     regs [32];
  logic [2:0]                alu_op;
  logic                      alu_src, mem_read, mem_write, reg_write;
  logic                      branch_eq, branch_ne, jump;
  logic [reg_addr_width-1:0] rs, rt, dst;
  logic [data_width-1:0]     rs_data, rt_data;

  assign rs = if_instr.i.rs;
  assign rt = if_instr.i.rt;

  ////////////////////////////////////////////////////////////////////////////
  // control decode
  always_comb begin
    alu_op    = alu_add;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    branch_eq = 1'b0;
    branch_ne = 1'b0;
    jump      = 1'b0;
    dst       = if_instr.i.rt;
    case (if_instr.i.opcode)
      op_rtype: begin
        dst       = if_instr.r.rd;
        reg_write = 1'b1;
        case (if_instr.r.funct)
          fn_add:  alu_op = alu_add;
          fn_sub:  alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_slt:  alu_op = alu_slt;
          default: reg_write = 1'b0;
        endcase
      end
      op_addi: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      op_andi: begin
        alu_op    = alu_and;
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      op_ori: begin
        alu_op    = alu_or;
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      op_lw: begin
        alu_src   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      op_sw: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      op_beq: begin
        alu_op    = alu_sub;
        branch_eq = 1'b1;
      end
      op_bne: begin
        alu_op    = alu_sub;
        branch_ne = 1'b1;
      end
      op_j:    jump = 1'b1;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // register file is written before it is read
  always_ff @(posedge clk) begin
    if (wb_write) begin
      regs[wb_reg] <= wb_data;
    end
  end

  function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] a);
    if (a == '0) begin
      return '0;
    end
    if (wb_write && wb_reg == a) begin
      return wb_data;
    end
    return regs[a];
  endfunction

  always_comb begin
    rs_data = read_reg(rs);
    rt_data = read_reg(rt);
  end

  // load-use hazard holds IF/ID one cycle and sends a bubble
  assign stall = if_valid && id_valid && id_mem_read && (id_rt == rs || id_rt == rt);

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX
  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      id_valid <= 1'b0;
    end else if (!hold) begin
      id_valid <= if_valid && !flush && !stall;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      id_pc        <= if_pc;
      id_alu_op    <= alu_op;
      id_alu_src   <= alu_src;
      id_mem_read  <= mem_read;
      id_mem_write <= mem_write;
      id_reg_write <= reg_write;
      id_branch_eq <= branch_eq;
      id_branch_ne <= branch_ne;
      id_jump      <= jump;
      id_rs        <= rs;
      id_rt        <= rt;
      id_dst       <= dst;
      id_rs_data   <= rs_data;
      id_rt_data   <= rt_data;
      id_imm       <= if_instr.i.imm;
    end
  end

  // the stalled instruction waits in IF/ID until the load moves on
  a_stall_keeps_ifid: assert property (@(posedge clk) disable iff (!rst_n)
    run && stall && !hold |=> if_valid && $stable(if_pc));

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
  parameter int imem_addr_width = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                run,
  input  logic                                hold,
  input  logic                                id_valid,
  input  logic [imem_addr_width-1:0]          id_pc,
  input  logic [2:0]                          id_alu_op,
  input  logic                                id_alu_src,
  input  logic                                id_mem_read,
  input  logic                                id_mem_write,
  input  logic                                id_reg_write,
  input  logic                                id_branch_eq,
  input  logic                                id_branch_ne,
  input  logic                                id_jump,
  input  logic [pipe_pkg::reg_addr_width-1:0] id_rs,
  input  logic [pipe_pkg::reg_addr_width-1:0] id_rt,
  input  logic [pipe_pkg::reg_addr_width-1:0] id_dst,
  input  logic [pipe_pkg::data_width-1:0]     id_rs_data,
  input  logic [pipe_pkg::data_width-1:0]     id_rt_data,
  input  logic [pipe_pkg::imm_width-1:0]      id_imm,
  input  logic                                wb_write,
  input  logic [pipe_pkg::reg_addr_width-1:0] wb_reg,
  input  logic [pipe_pkg::data_width-1:0]     wb_data,
  output logic                                flush,
  output logic [imem_addr_width-1:0]          redirect_pc,
  output logic                                ex_valid,
  output logic                                ex_mem_read,
  output logic                                ex_mem_write,
  output logic                                ex_reg_write,
  output logic [pipe_pkg::reg_addr_width-1:0] ex_dst,
  output logic [pipe_pkg::data_width-1:0]     ex_result,
  output logic [pipe_pkg::data_width-1:0]     ex_store_data
);
  import pipe_pkg::*;

  logic [data_width-1:0] fwd_a, fwd_b, op_b, alu_result;
  logic                  zero, taken;

  // EX/MEM first, then writeback; r0 is never forwarded
  function automatic logic [data_width-1:0] forward(
    input logic [reg_addr_width-1:0] src,
    input logic [data_width-1:0]     reg_data
  );
    if (src == '0) begin
      return reg_data;
    end
    if (ex_valid && ex_reg_write && ex_dst == src) begin
      return ex_result;
    end
    if (wb_write && wb_reg == src) begin
      return wb_data;
    end
    return reg_data;
  endfunction

  always_comb begin
    fwd_a = forward(id_rs, id_rs_data);
    fwd_b = forward(id_rt, id_rt_data);
  end

  assign op_b = id_alu_src ? {{(data_width - imm_width){1'b0}}, id_imm} : fwd_b;

  always_comb begin
    case (id_alu_op)
      alu_sub: alu_result = fwd_a - op_b;
      alu_and: alu_result = fwd_a & op_b;
      alu_or:  alu_result = fwd_a | op_b;
      alu_slt: alu_result = {{(data_width - 1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
      default: alu_result = fwd_a + op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // branch and jump resolution
  assign zero  = alu_result == '0;
  assign taken = (id_branch_eq && zero) || (id_branch_ne && !zero) || id_jump;
  assign flush = id_valid && taken;

  // branch target is relative to the next word
  assign redirect_pc = id_jump ? id_imm[imem_addr_width-1:0]
                               : id_pc + 1'b1 + id_imm[imem_addr_width-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM
  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      ex_valid <= 1'b0;
    end else if (!hold) begin
      ex_valid <= id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      ex_mem_read   <= id_mem_read;
      ex_mem_write  <= id_mem_write;
      ex_reg_write  <= id_reg_write;
      ex_dst        <= id_dst;
      ex_result     <= alu_result;
      ex_store_data <= fwd_b;
    end
  end

  // a taken branch leaves a bubble behind it in ID/EX
  a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    flush && !hold |=> !id_valid);

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
  parameter int dmem_addr_width = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                run,
  input  logic                                hold,
  input  logic                                ex_valid,
  input  logic                                ex_mem_read,
  input  logic                                ex_mem_write,
  input  logic                                ex_reg_write,
  input  logic [pipe_pkg::reg_addr_width-1:0] ex_dst,
  input  logic [pipe_pkg::data_width-1:0]     ex_result,
  input  logic [pipe_pkg::data_width-1:0]     ex_store_data,
  output logic                                mem_valid,
  output logic                                mem_reg_write,
  output logic                                mem_to_reg,
  output logic [pipe_pkg::reg_addr_width-1:0] mem_dst,
  output logic [pipe_pkg::data_width-1:0]     mem_alu_result,
  output logic [pipe_pkg::data_width-1:0]     mem_load_data
);
  import pipe_pkg::*;

  logic [data_width-1:0]      dmem [2**dmem_addr_width];
  logic [dmem_addr_width-1:0] addr;

  // word address, upper bits dropped
  assign addr = ex_result[dmem_addr_width-1:0];

  always_ff @(posedge clk) begin
    if (ex_valid && ex_mem_write && !hold) begin
      dmem[addr] <= ex_store_data;
    end
  end

  // MEM/WB
  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      mem_valid <= 1'b0;
    end else if (!hold) begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      mem_reg_write  <= ex_reg_write;
      mem_to_reg     <= ex_mem_read;
      mem_dst        <= ex_dst;
      mem_alu_result <= ex_result;
      mem_load_data  <= dmem[addr];
    end
  end

endmodule

//--- rtl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                mem_valid,
  input  logic                                mem_reg_write,
  input  logic                                mem_to_reg,
  input  logic [pipe_pkg::reg_addr_width-1:0] mem_dst,
  input  logic [pipe_pkg::data_width-1:0]     mem_alu_result,
  input  logic [pipe_pkg::data_width-1:0]     mem_load_data,
  input  logic                                retire_ready,
  output logic                                hold,
  output logic                                wb_write,
  output logic [pipe_pkg::reg_addr_width-1:0] wb_reg,
  output logic [pipe_pkg::data_width-1:0]     wb_data,
  output logic                                retire_valid,
  output logic [pipe_pkg::reg_addr_width-1:0] retire_reg,
  output logic [pipe_pkg::data_width-1:0]     retire_data
);

  assign wb_data      = mem_to_reg ? mem_load_data : mem_alu_result;
  assign wb_reg       = mem_dst;
  assign retire_valid = mem_valid && mem_reg_write && mem_dst != '0;
  assign retire_reg   = mem_dst;
  assign retire_data  = wb_data;

  // the register file only changes on a retire transfer
  assign wb_write = retire_valid && retire_ready;
  assign hold     = retire_valid && !retire_ready;

  // MEM/WB must stay frozen until the consumer takes it
  a_retire_stable: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=>
      retire_valid && $stable(retire_reg) && $stable(retire_data));

endmodule

//--- rtl/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core #(
  parameter int imem_addr_width = 8,
  parameter int dmem_addr_width = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                run,
  input  logic                                prog_valid,
  output logic                                prog_ready,
  input  logic [imem_addr_width-1:0]          prog_addr,
  input  pipe_pkg::instr_t                    prog_data,
  output logic                                retire_valid,
  input  logic                                retire_ready,
  output logic [pipe_pkg::reg_addr_width-1:0] retire_reg,
  output logic [pipe_pkg::data_width-1:0]     retire_data
);

  // hazard and hold controls
  logic                                stall, flush, hold;
  logic [imem_addr_width-1:0]          redirect_pc;

  // IF/ID
  logic                                if_valid;
  logic [imem_addr_width-1:0]          if_pc;
  pipe_pkg::instr_t                    if_instr;

  // ID/EX
  logic                                id_valid;
  logic [imem_addr_width-1:0]          id_pc;
  logic [2:0]                          id_alu_op;
  logic                                id_alu_src, id_mem_read, id_mem_write, id_reg_write;
  logic                                id_branch_eq, id_branch_ne, id_jump;
  logic [pipe_pkg::reg_addr_width-1:0] id_rs, id_rt, id_dst;
  logic [pipe_pkg::data_width-1:0]     id_rs_data, id_rt_data;
  logic [pipe_pkg::imm_width-1:0]      id_imm;

  // EX/MEM
  logic                                ex_valid, ex_mem_read, ex_mem_write, ex_reg_write;
  logic [pipe_pkg::reg_addr_width-1:0] ex_dst;
  logic [pipe_pkg::data_width-1:0]     ex_result, ex_store_data;

  // MEM/WB and writeback
  logic                                mem_valid, mem_reg_write, mem_to_reg;
  logic [pipe_pkg::reg_addr_width-1:0] mem_dst;
  logic [pipe_pkg::data_width-1:0]     mem_alu_result, mem_load_data;
  logic                                wb_write;
  logic [pipe_pkg::reg_addr_width-1:0] wb_reg;
  logic [pipe_pkg::data_width-1:0]     wb_data;

  fetch_stage #(.imem_addr_width(imem_addr_width)) u_fetch (.*);

  decode_stage #(.imem_addr_width(imem_addr_width)) u_decode (.*);

  execute_stage #(.imem_addr_width(imem_addr_width)) u_execute (.*);

  memory_stage #(.dmem_addr_width(dmem_addr_width)) u_memory (.*);

  writeback_stage u_writeback (.*);

endmodule

//--- sim/tb_pipeline_core.sv
`timescale 1ns/1ps

module tb_pipeline_core;
  import pipe_pkg::*;

  localparam int imem_addr_width = 8;
  localparam int dmem_addr_width = 8;
  localparam int max_words       = 1024;
  localparam int load_timeout    = 10;
  localparam int retire_timeout  = 200;
  localparam int drain_cycles    = 20;

  logic                       clk;
  logic                       rst_n;
  logic                       run;
  logic                       prog_valid;
  logic                       prog_ready;
  logic [imem_addr_width-1:0] prog_addr;
  instr_t                     prog_data;
  logic                       retire_valid;
  logic                       retire_ready;
  logic [reg_addr_width-1:0]  retire_reg;
  logic [data_width-1:0]      retire_data;

  // test records, three words each
  logic [31:0] vec [max_words];
  logic [31:0] load_addr_q[$];
  logic [31:0] load_word_q[$];
  logic [31:0] exp_reg_q[$];
  logic [31:0] exp_data_q[$];

  integer                    seed;
  logic                      random_ready;
  logic                      was_held;
  logic [reg_addr_width-1:0] held_reg;
  logic [data_width-1:0]     held_data;
  int                        test_num;

  pipeline_core #(
    .imem_addr_width(imem_addr_width),
    .dmem_addr_width(dmem_addr_width)
  ) u_pipeline_core (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one cycle: drive at the falling edge, outputs are settled by then
  task automatic step(output logic fire);
    integer rnd;
    @(negedge clk);
    rnd = $random(seed);
    retire_ready = random_ready ? rnd[0] : 1'b1;
    assert (prog_ready == !run) else begin
      $display("FAIL prog_ready: expected %h, got %h", !run, prog_ready);
      abort_run();
    end
    // a write that was refused last cycle must still be offered unchanged
    if (was_held) begin
      assert (retire_valid) else begin
        $display("retire_valid dropped before the offered write was taken");
        abort_run();
      end
      assert (retire_reg == held_reg) else begin
        $display("FAIL retire_reg under back-pressure: expected %h, got %h", held_reg, retire_reg);
        abort_run();
      end
      assert (retire_data == held_data) else begin
        $display("FAIL retire_data under back-pressure: expected %h, got %h",
                 held_data, retire_data);
        abort_run();
      end
    end
    was_held  = retire_valid && !retire_ready;
    held_reg  = retire_reg;
    held_data = retire_data;
    fire      = retire_valid && retire_ready;
  endtask

  task automatic load_program();
    logic fire;
    int   waited;
    for (int k = 0; k < load_addr_q.size(); k++) begin
      step(fire);
      prog_valid = 1'b1;
      prog_addr  = load_addr_q[k][imem_addr_width-1:0];
      prog_data  = load_word_q[k];
      waited     = 0;
      while (!prog_ready) begin
        if (waited == load_timeout) begin
          $display("program load timed out at word %0d of test %0d", k, test_num);
          abort_run();
        end
        waited++;
        step(fire);
      end
    end
    step(fire);
    prog_valid = 1'b0;
  endtask

  task automatic run_test(input logic back_pressure);
    logic fire;
    int   waited;
    test_num++;
    load_program();
    random_ready = back_pressure;
    step(fire);
    run = 1'b1;
    for (int k = 0; k < exp_reg_q.size(); k++) begin
      waited = 0;
      step(fire);
      while (!fire) begin
        if (waited == retire_timeout) begin
          $display("test %0d timed out waiting for retire %0d", test_num, k);
          abort_run();
        end
        waited++;
        step(fire);
      end
      assert (retire_reg == exp_reg_q[k][reg_addr_width-1:0]) else begin
        $display("FAIL retire_reg: expected %h, got %h", exp_reg_q[k][reg_addr_width-1:0],
                 retire_reg);
        abort_run();
      end
      assert (retire_data == exp_data_q[k]) else begin
        $display("FAIL retire_data: expected %h, got %h", exp_data_q[k], retire_data);
        abort_run();
      end
    end
    // program is parked on its final jump, nothing else may retire
    repeat (drain_cycles) begin
      step(fire);
      assert (!retire_valid) else begin
        $display("FAIL retire_valid: expected %h, got %h", 1'b0, retire_valid);
        abort_run();
      end
    end
    step(fire);
    run          = 1'b0;
    random_ready = 1'b0;
    $display("test %0d: %0d retires matched", test_num, exp_reg_q.size());
  endtask

  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int          idx;
    logic [31:0] tag;
    rst_n        = 1'b0;
    run          = 1'b0;
    prog_valid   = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    retire_ready = 1'b1;
    random_ready = 1'b0;
    was_held     = 1'b0;
    held_reg     = '0;
    held_data    = '0;
    seed         = 32'hadf01f7b;
    test_num     = 0;
    for (int k = 0; k < max_words; k++) begin
      vec[k] = '0;
    end
    $readmemh("sim/pipeline_core_tests.txt", vec);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idx = 0;
    while (idx + 2 < max_words && vec[idx] != 32'd0) begin
      tag = vec[idx];
      case (tag)
        32'd1: begin
          load_addr_q.push_back(vec[idx+1]);
          load_word_q.push_back(vec[idx+2]);
        end
        32'd2: begin
          exp_reg_q.push_back(vec[idx+1]);
          exp_data_q.push_back(vec[idx+2]);
        end
        32'd3: begin
          run_test(vec[idx+1][0]);
          load_addr_q.delete();
          load_word_q.delete();
          exp_reg_q.delete();
          exp_data_q.delete();
        end
        default: begin
          $display("unknown record tag %0h at word %0d of the tests file", tag, idx);
          abort_run();
        end
      endcase
      idx += 3;
    end
    assert (test_num > 0) else begin
      $display("the tests file holds no complete test");
      abort_run();
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- pipeline_core.f
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/pipeline_core.sv
sim/tb_pipeline_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_pipeline_core
FILELIST  := pipeline_core.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/pipeline_core_tests.txt
// record = tag a b, in hex; tag 1 program word (address, instruction),
// tag 2 expected retire (register, value), tag 3 end of test (back-pressure flag, 0)

// ALU ops, zero-extended immediates, signed slt
1 00 20010005   2 01 00000005   // addi r1, r0, 5
1 01 2002ffff   2 02 0000ffff   // addi r2, r0, 0xffff
1 02 34038001   2 03 00008001   // ori  r3, r0, 0x8001
1 03 30440f0f   2 04 00000f0f   // andi r4, r2, 0x0f0f
1 04 00222820   2 05 00010004   // add  r5, r1, r2
1 05 00223022   2 06 ffff0006   // sub  r6, r1, r2
1 06 00433824   2 07 00008001   // and  r7, r2, r3
1 07 00244025   2 08 00000f0f   // or   r8, r1, r4
1 08 00c1482a   2 09 00000001   // slt  r9, r6, r1
1 09 0026502a   2 0a 00000000   // slt  r10, r1, r6
1 0a 0800000a                   // j    10
3 00 00000000

// forwarding at every distance, r0 writes and reads
1 00 20010010   2 01 00000010   // addi r1, r0, 0x10
1 01 00211020   2 02 00000020   // add  r2, r1, r1
1 02 00221820   2 03 00000030   // add  r3, r1, r2
1 03 20201234                   // addi r0, r1, 0x1234
1 04 00032020   2 04 00000030   // add  r4, r0, r3
1 05 00602822   2 05 00000030   // sub  r5, r3, r0
1 06 00853025   2 06 00000030   // or   r6, r4, r5
1 07 00823820   2 07 00000050   // add  r7, r4, r2
1 08 08000008                   // j    8
3 00 00000000

// store, load back, load-use stall
1 00 20010007   2 01 00000007   // addi r1, r0, 7
1 01 3402beef   2 02 0000beef   // ori  r2, r0, 0xbeef
1 02 ac220003                   // sw   r2, 3(r1)
1 03 8c230003   2 03 0000beef   // lw   r3, 3(r1)
1 04 00612020   2 04 0000bef6   // add  r4, r3, r1
1 05 8c05000a   2 05 0000beef   // lw   r5, 10(r0)
1 06 00253020   2 06 0000bef6   // add  r6, r1, r5
1 07 08000007                   // j    7
3 00 00000000

// branches taken and not taken, jump over a word
1 00 20010003   2 01 00000003   // addi r1, r0, 3
1 01 20020003   2 02 00000003   // addi r2, r0, 3
1 02 10220002                   // beq  r1, r2, +2 taken
1 03 20030bad                   // skipped
1 04 20040bad                   // skipped
1 05 14220001                   // bne  r1, r2, +1 not taken
1 06 20050055   2 05 00000055   // addi r5, r0, 0x55
1 07 14250001                   // bne  r1, r5, +1 taken
1 08 20060bad                   // skipped
1 09 10250001                   // beq  r1, r5, +1 not taken
1 0a 0800000c                   // j    12
1 0b 20070bad                   // skipped
1 0c 20080077   2 08 00000077   // addi r8, r0, 0x77
1 0d 0800000d                   // j    13
3 00 00000000

// mixed program under random retire back-pressure
1 00 20010100   2 01 00000100   // addi r1, r0, 0x100
1 01 20220023   2 02 00000123   // addi r2, r1, 0x23
1 02 ac020000                   // sw   r2, 0(r0)
1 03 8c030000   2 03 00000123   // lw   r3, 0(r0)
1 04 00612022   2 04 00000023   // sub  r4, r3, r1
1 05 0082282a   2 05 00000001   // slt  r5, r4, r2
1 06 10a00001                   // beq  r5, r0, +1 not taken
1 07 00813025   2 06 00000123   // or   r6, r4, r1
1 08 14c20001                   // bne  r6, r2, +1 not taken
1 09 00c53820   2 07 00000124   // add  r7, r6, r5
1 0a 0800000a                   // j    10
3 01 00000000

0 00 00000000
